/* source/ooo_macros.svh */
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath width
`define OOO_XLEN 32

// structure depths
`define OOO_IQ_DEPTH 4
`define OOO_ROB_DEPTH 8
`define OOO_ROB_IX_W 3  // log2 of the ROB depth
`define OOO_RS_DEPTH 2

`endif

/* source/ooo_isa_pkg.sv */
package ooo_isa_pkg;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_OP    = 7'b0110011,  // register-register
    OPC_OPIMM = 7'b0010011   // register-immediate
  } rv_opcode_e;

  typedef enum logic [1:0] {
    CLASS_NOP,    // unsupported, dropped at the queue head
    CLASS_OP,
    CLASS_OPIMM
  } op_class_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,  // signed
    ALU_SLL,
    ALU_SRL,
    ALU_MUL   // low word only
  } alu_func_e;

endpackage

/* source/ooo_core_pkg.sv */
package ooo_core_pkg;

  // reorder buffer entry
  typedef enum logic [1:0] {
    ROB_FREE,
    ROB_PENDING,  // waiting for its result on the bus
    ROB_DONE
  } rob_state_e;

  // reservation station entry
  typedef enum logic [1:0] {
    RS_EMPTY,
    RS_WAITING,  // at least one operand still tagged
    RS_READY
  } rs_state_e;

endpackage

/* source/decode_queue.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module decode_queue (
  input  logic                    clk_100mhz,
  input  logic                    rst_n,
  input  logic [31:0]             instruction,
  input  logic                    instruction_valid,
  input  logic                    rob_ready,
  input  logic                    rs_ready,
  output logic                    queue_ready,
  output logic                    issue,
  output ooo_isa_pkg::alu_func_e  issue_func,
  output logic [4:0]              issue_rs1,
  output logic [4:0]              issue_rs2,
  output logic [4:0]              issue_rd,
  output logic [`OOO_XLEN-1:0]    issue_imm,
  output logic                    issue_use_imm
);
  import ooo_isa_pkg::*;

  localparam int IX_W = $clog2(`OOO_IQ_DEPTH);
  localparam logic [IX_W:0] FULL = `OOO_IQ_DEPTH;

  rv_opcode_e opcode;
  op_class_e  dec_cls;
  alu_func_e  dec_func;

  op_class_e          cls_q  [`OOO_IQ_DEPTH];
  alu_func_e          func_q [`OOO_IQ_DEPTH];
  logic [4:0]         rs1_q  [`OOO_IQ_DEPTH];
  logic [4:0]         rs2_q  [`OOO_IQ_DEPTH];
  logic [4:0]         rd_q   [`OOO_IQ_DEPTH];
  logic [`OOO_XLEN-1:0] imm_q [`OOO_IQ_DEPTH];

  logic [IX_W-1:0] head, tail;  // depth is a power of two, pointers wrap
  logic [IX_W:0]   count;
  logic            push, pop, head_valid, head_nop;

  assign opcode = rv_opcode_e'(instruction[6:0]);

  always_comb begin
    dec_cls  = CLASS_NOP;
    dec_func = ALU_ADD;
    case (opcode)
      OPC_OP: begin
        dec_cls = CLASS_OP;
        case ({instruction[31:25], instruction[14:12]})
          {7'h00, 3'b000}: dec_func = ALU_ADD;
          {7'h20, 3'b000}: dec_func = ALU_SUB;
          {7'h00, 3'b111}: dec_func = ALU_AND;
          {7'h00, 3'b110}: dec_func = ALU_OR;
          {7'h00, 3'b100}: dec_func = ALU_XOR;
          {7'h00, 3'b010}: dec_func = ALU_SLT;
          {7'h00, 3'b001}: dec_func = ALU_SLL;
          {7'h00, 3'b101}: dec_func = ALU_SRL;
          {7'h01, 3'b000}: dec_func = ALU_MUL;
          default:         dec_cls  = CLASS_NOP;
        endcase
      end
      OPC_OPIMM: begin
        dec_cls = CLASS_OPIMM;
        case (instruction[14:12])
          3'b000: dec_func = ALU_ADD;
          3'b111: dec_func = ALU_AND;
          3'b110: dec_func = ALU_OR;
          3'b100: dec_func = ALU_XOR;
          3'b010: dec_func = ALU_SLT;
          3'b001: dec_func = ALU_SLL;
          3'b101: dec_func = ALU_SRL;  // srai falls out below
          default: dec_cls = CLASS_NOP;
        endcase
        // shift immediates need a zero funct7
        if (instruction[12] && instruction[13:12] == 2'b01 && instruction[31:25] != 7'h00)
          dec_cls = CLASS_NOP;
      end
      default: ;
    endcase
  end

  assign queue_ready = (count != FULL);
  assign push        = instruction_valid && queue_ready;
  assign head_valid  = (count != '0);
  assign head_nop    = (cls_q[head] == CLASS_NOP);
  assign issue       = head_valid && !head_nop && rob_ready && rs_ready;
  assign pop         = issue || (head_valid && head_nop);  // nops just vanish

  assign issue_func    = func_q[head];
  assign issue_rs1     = rs1_q[head];
  assign issue_rs2     = rs2_q[head];
  assign issue_rd      = rd_q[head];
  assign issue_imm     = imm_q[head];
  assign issue_use_imm = (cls_q[head] == CLASS_OPIMM);

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (!push && pop) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (push) begin
      cls_q[tail]  <= dec_cls;
      func_q[tail] <= dec_func;
      rs1_q[tail]  <= instruction[19:15];
      rs2_q[tail]  <= instruction[24:20];
      rd_q[tail]   <= instruction[11:7];
      imm_q[tail]  <= {{(`OOO_XLEN-12){instruction[31]}}, instruction[31:20]};
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module register_file (
  input  logic                     clk_100mhz,
  input  logic                     rst_n,
  input  logic [4:0]               rs1,
  input  logic [4:0]               rs2,
  input  logic                     rename,
  input  logic [4:0]               rename_rd,
  input  logic [`OOO_ROB_IX_W-1:0] rename_tag,
  input  logic                     commit_valid,
  input  logic [4:0]               commit_rd,
  input  logic [`OOO_XLEN-1:0]     commit_value,
  input  logic [`OOO_ROB_IX_W-1:0] commit_tag,
  output logic [`OOO_XLEN-1:0]     rs1_value,
  output logic                     rs1_busy,
  output logic [`OOO_ROB_IX_W-1:0] rs1_tag,
  output logic [`OOO_XLEN-1:0]     rs2_value,
  output logic                     rs2_busy,
  output logic [`OOO_ROB_IX_W-1:0] rs2_tag
);

  logic [`OOO_XLEN-1:0]     regs [32];
  logic [`OOO_ROB_IX_W-1:0] tags [32];  // youngest producer of each register
  logic [31:0]              busy;

  // reads see the mapping before this cycle's rename
  assign rs1_value = regs[rs1];
  assign rs1_busy  = busy[rs1];
  assign rs1_tag   = tags[rs1];
  assign rs2_value = regs[rs2];
  assign rs2_busy  = busy[rs2];
  assign rs2_tag   = tags[rs2];

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < 32; i++) regs[i] <= '0;  // architectural state starts at zero
    end else begin
      if (commit_valid && commit_rd != 5'd0) begin
        regs[commit_rd] <= commit_value;
        if (tags[commit_rd] == commit_tag) busy[commit_rd] <= 1'b0;  // older tag leaves it busy
      end
      // a rename in the same cycle overrides the clear
      if (rename && rename_rd != 5'd0) busy[rename_rd] <= 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (rename && rename_rd != 5'd0) tags[rename_rd] <= rename_tag;
  end

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module reorder_buffer (
  input  logic                     clk_100mhz,
  input  logic                     rst_n,
  input  logic                     alloc,
  input  logic [4:0]               alloc_rd,
  input  logic [`OOO_ROB_IX_W-1:0] lookup1_tag,
  input  logic [`OOO_ROB_IX_W-1:0] lookup2_tag,
  input  logic                     cdb_valid,
  input  logic [`OOO_ROB_IX_W-1:0] cdb_tag,
  input  logic [`OOO_XLEN-1:0]     cdb_value,
  output logic                     rob_ready,
  output logic [`OOO_ROB_IX_W-1:0] alloc_tag,
  output logic                     lookup1_done,
  output logic [`OOO_XLEN-1:0]     lookup1_value,
  output logic                     lookup2_done,
  output logic [`OOO_XLEN-1:0]     lookup2_value,
  output logic                     commit_valid,
  output logic [4:0]               commit_rd,
  output logic [`OOO_XLEN-1:0]     commit_value,
  output logic [`OOO_ROB_IX_W-1:0] commit_tag
);
  import ooo_core_pkg::*;

  localparam logic [`OOO_ROB_IX_W:0] FULL = `OOO_ROB_DEPTH;

  rob_state_e           state   [`OOO_ROB_DEPTH];
  logic [4:0]           rd_q    [`OOO_ROB_DEPTH];
  logic [`OOO_XLEN-1:0] value_q [`OOO_ROB_DEPTH];

  logic [`OOO_ROB_IX_W-1:0] head, tail;
  logic [`OOO_ROB_IX_W:0]   count;

  assign rob_ready = (count != FULL);
  assign alloc_tag = tail;  // the tag is the entry index

  // forwarding of finished but uncommitted results
  assign lookup1_done  = (state[lookup1_tag] == ROB_DONE);
  assign lookup1_value = value_q[lookup1_tag];
  assign lookup2_done  = (state[lookup2_tag] == ROB_DONE);
  assign lookup2_value = value_q[lookup2_tag];

  // retire strictly from the head
  assign commit_valid = (state[head] == ROB_DONE);
  assign commit_rd    = rd_q[head];
  assign commit_value = value_q[head];
  assign commit_tag   = head;

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      for (int i = 0; i < `OOO_ROB_DEPTH; i++) state[i] <= ROB_FREE;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        state[tail] <= ROB_PENDING;
        tail        <= tail + 1'b1;
      end
      if (cdb_valid) state[cdb_tag] <= ROB_DONE;
      if (commit_valid) begin
        state[head] <= ROB_FREE;
        head        <= head + 1'b1;
      end
      if (alloc && !commit_valid) count <= count + 1'b1;
      else if (!alloc && commit_valid) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (alloc) rd_q[tail] <= alloc_rd;
    if (cdb_valid) value_q[cdb_tag] <= cdb_value;
  end

endmodule

/* source/reservation_station.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module reservation_station (
  input  logic                     clk_100mhz,
  input  logic                     rst_n,
  input  logic                     issue,
  input  ooo_isa_pkg::alu_func_e   issue_func,
  input  logic [`OOO_ROB_IX_W-1:0] issue_tag,
  input  logic [`OOO_XLEN-1:0]     issue_imm,
  input  logic                     issue_use_imm,
  input  logic [`OOO_XLEN-1:0]     rs1_value,
  input  logic                     rs1_busy,
  input  logic [`OOO_ROB_IX_W-1:0] rs1_tag,
  input  logic [`OOO_XLEN-1:0]     rs2_value,
  input  logic                     rs2_busy,
  input  logic [`OOO_ROB_IX_W-1:0] rs2_tag,
  input  logic                     lookup1_done,
  input  logic [`OOO_XLEN-1:0]     lookup1_value,
  input  logic                     lookup2_done,
  input  logic [`OOO_XLEN-1:0]     lookup2_value,
  input  logic                     cdb_valid,
  input  logic [`OOO_ROB_IX_W-1:0] cdb_tag,
  input  logic [`OOO_XLEN-1:0]     cdb_value,
  output logic                     rs_ready,
  output logic                     exec_valid,
  output ooo_isa_pkg::alu_func_e   exec_func,
  output logic [`OOO_XLEN-1:0]     exec_a,
  output logic [`OOO_XLEN-1:0]     exec_b,
  output logic [`OOO_ROB_IX_W-1:0] exec_tag
);
  import ooo_isa_pkg::*;
  import ooo_core_pkg::*;

  localparam int D = `OOO_RS_DEPTH;
  localparam int SLOT_W = (D > 1) ? $clog2(D) : 1;

  rs_state_e                state [D];
  alu_func_e                func_q [D];
  logic [`OOO_ROB_IX_W-1:0] tag_q [D];
  logic [`OOO_XLEN-1:0]     a_val [D], b_val [D];
  logic [`OOO_ROB_IX_W-1:0] a_tag [D], b_tag [D];
  logic [D-1:0]             a_rdy, b_rdy, a_hit, b_hit;
  logic [D-1:0]             older [D];  // older[i][j] set when entry i came before j
  logic [D-1:0]             ready, pick;
  logic [SLOT_W-1:0]        free_slot;
  logic [`OOO_XLEN:0]       a_res, b_res;  // {ready, value} at capture

  // operand source at capture: register file, then ROB, then the bus this cycle
  function automatic logic [`OOO_XLEN:0] resolve(
    input logic busy, input logic [`OOO_ROB_IX_W-1:0] tag, input logic [`OOO_XLEN-1:0] rf_value,
    input logic rob_done, input logic [`OOO_XLEN-1:0] rob_value,
    input logic bus_valid, input logic [`OOO_ROB_IX_W-1:0] bus_tag,
    input logic [`OOO_XLEN-1:0] bus_value);
    if (!busy) return {1'b1, rf_value};
    if (rob_done) return {1'b1, rob_value};
    if (bus_valid && bus_tag == tag) return {1'b1, bus_value};
    return {1'b0, rf_value};
  endfunction

  always_comb begin
    a_res = resolve(rs1_busy, rs1_tag, rs1_value, lookup1_done, lookup1_value,
                    cdb_valid, cdb_tag, cdb_value);
    b_res = resolve(rs2_busy, rs2_tag, rs2_value, lookup2_done, lookup2_value,
                    cdb_valid, cdb_tag, cdb_value);
    if (issue_use_imm) b_res = {1'b1, issue_imm};
  end

  always_comb begin
    free_slot = '0;
    rs_ready  = 1'b0;
    for (int i = D - 1; i >= 0; i--) begin
      ready[i] = (state[i] == RS_READY);
      a_hit[i] = (state[i] == RS_WAITING) && cdb_valid && !a_rdy[i] && a_tag[i] == cdb_tag;
      b_hit[i] = (state[i] == RS_WAITING) && cdb_valid && !b_rdy[i] && b_tag[i] == cdb_tag;
      if (state[i] == RS_EMPTY) begin
        free_slot = SLOT_W'(i);  // lowest empty slot wins
        rs_ready  = 1'b1;
      end
    end
  end

  // oldest ready entry goes first
  always_comb begin
    logic [D-1:0] rivals;
    for (int i = 0; i < D; i++) begin
      rivals    = ready & ~older[i];
      rivals[i] = 1'b0;
      pick[i]   = ready[i] && (rivals == '0);
    end
  end

  always_comb begin
    exec_valid = |pick;
    exec_func  = ALU_ADD;
    exec_a     = '0;
    exec_b     = '0;
    exec_tag   = '0;
    for (int i = 0; i < D; i++) begin
      if (pick[i]) begin
        exec_func = func_q[i];
        exec_a    = a_val[i];
        exec_b    = b_val[i];
        exec_tag  = tag_q[i];
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      a_rdy <= '0;
      b_rdy <= '0;
      for (int i = 0; i < D; i++) begin
        state[i] <= RS_EMPTY;
        older[i] <= '0;
      end
    end else begin
      for (int i = 0; i < D; i++) begin
        if (pick[i]) state[i] <= RS_EMPTY;
        if (a_hit[i]) a_rdy[i] <= 1'b1;
        if (b_hit[i]) b_rdy[i] <= 1'b1;
        if (state[i] == RS_WAITING && (a_rdy[i] || a_hit[i]) && (b_rdy[i] || b_hit[i]))
          state[i] <= RS_READY;
      end
      if (issue) begin
        state[free_slot] <= (a_res[`OOO_XLEN] && b_res[`OOO_XLEN]) ? RS_READY : RS_WAITING;
        a_rdy[free_slot] <= a_res[`OOO_XLEN];
        b_rdy[free_slot] <= b_res[`OOO_XLEN];
        for (int j = 0; j < D; j++) begin
          older[free_slot][j] <= 1'b0;  // newcomer is the youngest
          if (SLOT_W'(j) != free_slot) older[j][free_slot] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < D; i++) begin
      if (a_hit[i]) a_val[i] <= cdb_value;
      if (b_hit[i]) b_val[i] <= cdb_value;
    end
    if (issue) begin
      func_q[free_slot] <= issue_func;
      tag_q[free_slot]  <= issue_tag;
      a_val[free_slot]  <= a_res[`OOO_XLEN-1:0];
      b_val[free_slot]  <= b_res[`OOO_XLEN-1:0];
      a_tag[free_slot]  <= rs1_tag;
      b_tag[free_slot]  <= rs2_tag;
    end
  end

endmodule

/* source/alu.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module alu (
  input  logic                     clk_100mhz,
  input  logic                     rst_n,
  input  logic                     exec_valid,
  input  ooo_isa_pkg::alu_func_e   exec_func,
  input  logic [`OOO_XLEN-1:0]     exec_a,
  input  logic [`OOO_XLEN-1:0]     exec_b,
  input  logic [`OOO_ROB_IX_W-1:0] exec_tag,
  output logic                     cdb_valid,
  output logic [`OOO_ROB_IX_W-1:0] cdb_tag,
  output logic [`OOO_XLEN-1:0]     cdb_value
);
  import ooo_isa_pkg::*;

  logic [`OOO_XLEN-1:0] result;

  always_comb begin
    case (exec_func)
      ALU_ADD: result = exec_a + exec_b;
      ALU_SUB: result = exec_a - exec_b;
      ALU_AND: result = exec_a & exec_b;
      ALU_OR:  result = exec_a | exec_b;
      ALU_XOR: result = exec_a ^ exec_b;
      ALU_SLT: result = {{(`OOO_XLEN-1){1'b0}}, $signed(exec_a) < $signed(exec_b)};
      ALU_SLL: result = exec_a << exec_b[4:0];
      ALU_SRL: result = exec_a >> exec_b[4:0];
      ALU_MUL: result = exec_a * exec_b;  // truncates to the low word
      default: result = '0;
    endcase
  end

  // the bus has this unit as its only driver
  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) cdb_valid <= 1'b0;
    else cdb_valid <= exec_valid;
  end

  always_ff @(posedge clk_100mhz) begin
    if (exec_valid) begin
      cdb_tag   <= exec_tag;
      cdb_value <= result;
    end
  end

endmodule

/* source/ooo_core.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module ooo_core (
  input  logic                 clk_100mhz,
  input  logic                 rst_n,
  input  logic [31:0]          instruction,
  input  logic                 instruction_valid,
  output logic                 queue_ready,
  output logic                 commit_valid,
  output logic [4:0]           commit_rd,
  output logic [`OOO_XLEN-1:0] commit_value
);
  import ooo_isa_pkg::*;

  logic                     rob_ready, rs_ready, issue, issue_use_imm;
  alu_func_e                issue_func, exec_func;
  logic [4:0]               issue_rs1, issue_rs2, issue_rd;
  logic [`OOO_XLEN-1:0]     issue_imm;
  logic [`OOO_ROB_IX_W-1:0] alloc_tag, commit_tag;
  logic [`OOO_XLEN-1:0]     rs1_value, rs2_value;
  logic                     rs1_busy, rs2_busy;
  logic [`OOO_ROB_IX_W-1:0] rs1_tag, rs2_tag;
  logic                     lookup1_done, lookup2_done;
  logic [`OOO_XLEN-1:0]     lookup1_value, lookup2_value;
  logic                     exec_valid, cdb_valid;
  logic [`OOO_XLEN-1:0]     exec_a, exec_b, cdb_value;
  logic [`OOO_ROB_IX_W-1:0] exec_tag, cdb_tag;

  decode_queue u_queue (
    .clk_100mhz, .rst_n, .instruction, .instruction_valid,
    .rob_ready, .rs_ready, .queue_ready, .issue, .issue_func,
    .issue_rs1, .issue_rs2, .issue_rd, .issue_imm, .issue_use_imm
  );

  register_file u_regs (
    .clk_100mhz, .rst_n,
    .rs1        (issue_rs1),
    .rs2        (issue_rs2),
    .rename     (issue),
    .rename_rd  (issue_rd),
    .rename_tag (alloc_tag),
    .commit_valid, .commit_rd, .commit_value, .commit_tag,
    .rs1_value, .rs1_busy, .rs1_tag, .rs2_value, .rs2_busy, .rs2_tag
  );

  reorder_buffer u_rob (
    .clk_100mhz, .rst_n,
    .alloc       (issue),
    .alloc_rd    (issue_rd),
    .lookup1_tag (rs1_tag),  // tags straight from the rename table
    .lookup2_tag (rs2_tag),
    .cdb_valid, .cdb_tag, .cdb_value,
    .rob_ready, .alloc_tag, .lookup1_done, .lookup1_value, .lookup2_done, .lookup2_value,
    .commit_valid, .commit_rd, .commit_value, .commit_tag
  );

  reservation_station u_rs (
    .clk_100mhz, .rst_n, .issue, .issue_func,
    .issue_tag (alloc_tag),
    .issue_imm, .issue_use_imm,
    .rs1_value, .rs1_busy, .rs1_tag, .rs2_value, .rs2_busy, .rs2_tag,
    .lookup1_done, .lookup1_value, .lookup2_done, .lookup2_value,
    .cdb_valid, .cdb_tag, .cdb_value,
    .rs_ready, .exec_valid, .exec_func, .exec_a, .exec_b, .exec_tag
  );

  alu u_alu (
    .clk_100mhz, .rst_n, .exec_valid, .exec_func, .exec_a, .exec_b, .exec_tag,
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

/* sim/ooo_core_sva.sv */
`timescale 1ns/10ps

module ooo_core_sva (
  input logic clk_100mhz,
  input logic rst_n,
  input logic instruction_valid,
  input logic queue_ready,
  input logic commit_valid
);

  // the source has to respect a full queue
  strobe_needs_room: assert property (
    @(posedge clk_100mhz) disable iff (!rst_n) instruction_valid |-> queue_ready
  ) else $error("instruction strobe while the queue is full");

  commit_known: assert property (
    @(posedge clk_100mhz) disable iff (!rst_n) !$isunknown(commit_valid)
  ) else $error("commit_valid is unknown");

  // nothing can retire in the first cycle out of reset
  quiet_after_reset: assert property (
    @(posedge clk_100mhz) $rose(rst_n) |-> !commit_valid
  ) else $error("commit_valid high right after reset release");

endmodule

bind ooo_core ooo_core_sva u_sva (
  .clk_100mhz        (clk_100mhz),
  .rst_n             (rst_n),
  .instruction_valid (instruction_valid),
  .queue_ready       (queue_ready),
  .commit_valid      (commit_valid)
);

/* sim/ooo_core_tb.sv */
`timescale 1ns/10ps
`include "ooo_macros.svh"

module ooo_core_tb;
  import ooo_isa_pkg::*;

  localparam int MAX_VEC   = 64;
  localparam int BURST_LEN = 8;  // strobes sent back to back

  logic                 clk_100mhz = 1'b0;
  logic                 rst_n;
  logic [31:0]          instruction;
  logic                 instruction_valid;
  logic                 queue_ready;
  logic                 commit_valid;
  logic [4:0]           commit_rd;
  logic [`OOO_XLEN-1:0] commit_value;

  // each vector is four words of instruction, commits flag, rd and value
  logic [31:0] vec_mem [4*MAX_VEC];
  int          num_vec = 0;
  int          num_commits = 0;
  int          seen = 0;
  int          next_vec = 0;  // vector the next commit is matched against
  bit          loaded = 1'b0;

  ooo_core dut (
    .clk_100mhz, .rst_n, .instruction, .instruction_valid,
    .queue_ready, .commit_valid, .commit_rd, .commit_value
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_commit();
    logic [4:0]  exp_rd;
    logic [31:0] exp_value;
    assert (seen < num_commits)
      else stop_with_failure("a commit arrived after every expected commit was seen");
    while (vec_mem[4*next_vec+1] != 32'd1) next_vec++;  // dropped encodings never commit
    exp_rd    = vec_mem[4*next_vec+2][4:0];
    exp_value = vec_mem[4*next_vec+3];
    assert (commit_rd == exp_rd && commit_value == exp_value)
      else stop_with_failure($sformatf(
        "ERROR at %0t: vector %0d expected rd x%0d value %h, got rd x%0d value %h",
        $time, next_vec, exp_rd, exp_value, commit_rd, commit_value));
    next_vec++;
    seen++;
  endtask

  // sample mid-cycle once outputs have settled
  always @(negedge clk_100mhz) begin
    if (rst_n && commit_valid) check_commit();
  end

  initial begin
    logic [31:0] lcg_state;
    int          gap;
    int          burst_start;
    rst_n             = 1'b0;
    instruction       = '0;
    instruction_valid = 1'b0;
    lcg_state         = 32'd64;
    for (int i = 0; i < 4*MAX_VEC; i++) vec_mem[i] = ~32'(i);  // flag words end up above 1
    $readmemh("sim/ooo_core_vectors.txt", vec_mem);
    while (num_vec < MAX_VEC && vec_mem[4*num_vec+1] <= 32'd1) begin
      if (vec_mem[4*num_vec+1] == 32'd1) begin
        num_commits++;
        assert (vec_mem[4*num_vec][6:0] inside {OPC_OP, OPC_OPIMM})
          else stop_with_failure($sformatf(
            "vector %0d expects a commit from an unsupported opcode", num_vec));
      end
      num_vec++;
    end
    if (num_commits == 0) stop_with_failure("the vector file holds no committing instruction");
    loaded      = 1'b1;
    burst_start = num_vec / 2;

    repeat (8) @(negedge clk_100mhz);
    rst_n = 1'b1;
    assert (queue_ready)
      else stop_with_failure("queue_ready is low right after reset was released");

    for (int i = 0; i < num_vec; i++) begin
      lcg_state = lcg_next(lcg_state);
      gap = (i >= burst_start && i < burst_start + BURST_LEN) ? 0 : int'(lcg_state[17:16]);
      repeat (gap) @(negedge clk_100mhz);
      while (!queue_ready) @(negedge clk_100mhz);  // hold off while full
      instruction       = vec_mem[4*i];
      instruction_valid = 1'b1;
      @(negedge clk_100mhz);
      instruction_valid = 1'b0;
    end

    wait (seen == num_commits);
    repeat (10) @(negedge clk_100mhz);  // time for a stray extra commit to show up
    $display("TEST RESULT: PASS");
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (num_vec * 20 + 200) @(posedge clk_100mhz);
    stop_with_failure("watchdog expired because commits stopped arriving");
  end

endmodule

/* ooo_core.f */
+incdir+source
source/ooo_isa_pkg.sv
source/ooo_core_pkg.sv
source/decode_queue.sv
source/register_file.sv
source/reorder_buffer.sv
source/reservation_station.sv
source/alu.sv
source/ooo_core.sv
sim/ooo_core_sva.sv
sim/ooo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ooo_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ooo_core_tb -f ooo_core.f -o ooo_core_sim

out=$(./obj_dir/ooo_core_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"

/* sim/ooo_core_vectors.txt */
// instruction  commits  rd  value (all hex), registers start at zero
// a commits flag of 0 marks an encoding that is dropped without a commit
00500093 1 01 00000005  // addi x1, x0, 5
FFD00113 1 02 FFFFFFFD  // addi x2, x0, -3
002081B3 1 03 00000002  // add  x3, x1, x2
40208233 1 04 00000008  // sub  x4, x1, x2
001122B3 1 05 00000001  // slt  x5, x2, x1
02120333 1 06 00000028  // mul  x6, x4, x1
00000000 0 00 00000000  // unsupported
004093B3 1 07 00000500  // sll  x7, x1, x4
01C15413 1 08 0000000F  // srli x8, x2, 28
0FF3C493 1 09 000005FF  // xori x9, x7, 0xff
00118193 1 03 00000003  // addi x3, x3, 1
0081E533 1 0A 0000000F  // or   x10, x3, x8
00708013 1 00 0000000C  // addi x0, x1, 7
001005B3 1 0B 00000005  // add  x11, x0, x1
4020C633 0 00 00000000  // unsupported funct7 on xor
02210633 1 0C 00000009  // mul  x12, x2, x2
FFF12693 1 0D 00000001  // slti x13, x2, -1
00467733 1 0E 00000008  // and  x14, x12, x4
002097B3 1 0F A0000000  // sll  x15, x1, x2
00B7D833 1 10 05000000  // srl  x16, x15, x11
